/* Bender.yml */
package:
  name: pkt_buf

sources:
  # src
  - files:
      - src/pkt_buf_pkg.sv
      - src/frame_len_check.sv
      - src/axis_frame_fifo.sv
      - src/frame_stat_regs.sv
      - src/pkt_buf_top.sv
  # verification
  - target: test
    files:
      - verification/pkt_buf_sva.sv
      - verification/pkt_buf_tb.sv

/* sources.f */
src/pkt_buf_pkg.sv
src/frame_len_check.sv
src/axis_frame_fifo.sv
src/frame_stat_regs.sv
src/pkt_buf_top.sv
verification/pkt_buf_sva.sv
verification/pkt_buf_tb.sv

/* src/axis_frame_fifo.sv */
`timescale 1ns/1ps

module axis_frame_fifo import pkt_buf_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 6,
  parameter bit DROP_WHEN_FULL  = 1'b1
) (
  input  logic  clk,
  input  logic  rst,
  input  data_t s_tdata,
  input  keep_t s_tkeep,
  input  logic  s_tlast,
  input  logic  s_tuser,
  input  logic  s_tvalid,
  output logic  s_tready,
  output data_t m_tdata,
  output keep_t m_tkeep,
  output logic  m_tlast,
  output logic  m_tvalid,
  input  logic  m_tready,
  output logic  good_frame,
  output logic  bad_frame,
  output logic  overflow
);

  localparam int AW     = FIFO_ADDR_WIDTH;
  localparam int WORD_W = $bits(data_t) + $bits(keep_t) + 1;

  // one extra bit tells a full FIFO from an empty one.
  typedef logic [AW:0] ptr_t;

  logic [WORD_W-1:0] mem [2**AW];

  ptr_t wr_ptr_commit;
  ptr_t wr_ptr_cur;
  ptr_t rd_ptr;
  ptr_t rd_ptr_next;

  logic empty_q;
  logic drop_frame;
  logic full_cur;
  logic full_wr;
  logic accept;
  logic drop_beat;
  logic write;
  logic read;
  logic store_output;

  logic [WORD_W-1:0] mem_rd_data;
  logic              mem_rd_valid;
  logic [WORD_W-1:0] out_data;
  logic              out_valid;

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------

  // full_cur means no room for another beat; full_wr means the frame being
  // written alone fills the whole memory and can never be committed.
  assign full_cur = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                    (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);
  assign full_wr  = (wr_ptr_cur[AW] != wr_ptr_commit[AW]) &&
                    (wr_ptr_cur[AW-1:0] == wr_ptr_commit[AW-1:0]);

  assign s_tready  = !full_cur || full_wr || DROP_WHEN_FULL;
  assign accept    = s_tvalid && s_tready;
  assign drop_beat = full_cur || full_wr || drop_frame;
  assign write     = accept && !drop_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_commit <= '0;
      wr_ptr_cur    <= '0;
      drop_frame    <= 1'b0;
      good_frame    <= 1'b0;
      bad_frame     <= 1'b0;
      overflow      <= 1'b0;
    end else begin
      good_frame <= 1'b0;
      bad_frame  <= 1'b0;
      overflow   <= 1'b0;
      if (accept) begin
        if (drop_beat) begin
          // swallow the rest of the frame, then forget it.
          drop_frame <= 1'b1;
          if (s_tlast) begin
            wr_ptr_cur <= wr_ptr_commit;
            drop_frame <= 1'b0;
            // a frame that is bad anyway is counted as bad.
            if (s_tuser) begin
              bad_frame <= 1'b1;
            end else begin
              overflow <= 1'b1;
            end
          end
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
          if (s_tlast) begin
            if (s_tuser) begin
              wr_ptr_cur <= wr_ptr_commit;
              bad_frame  <= 1'b1;
            end else begin
              wr_ptr_commit <= wr_ptr_cur + 1'b1;
              good_frame    <= 1'b1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[AW-1:0]] <= {s_tlast, s_tkeep, s_tdata};
    end
  end

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------

  // the memory read stage refills whenever the output stage takes its word,
  // so a stalled output keeps both stages loaded.
  always_comb begin
    store_output = m_tready || !out_valid;
    read         = !empty_q && (store_output || !mem_rd_valid);
    rd_ptr_next  = rd_ptr;
    if (read) begin
      rd_ptr_next = rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      empty_q      <= 1'b1;
      mem_rd_valid <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      rd_ptr  <= rd_ptr_next;
      // registered empty flag, so a commit shows up one cycle later.
      empty_q <= (wr_ptr_commit == rd_ptr_next);
      if (store_output || !mem_rd_valid) begin
        mem_rd_valid <= read;
      end
      if (store_output) begin
        out_valid <= mem_rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_data <= mem[rd_ptr[AW-1:0]];
    end
    if (store_output) begin
      out_data <= mem_rd_data;
    end
  end

  assign {m_tlast, m_tkeep, m_tdata} = out_data;
  assign m_tvalid = out_valid;

endmodule

/* src/frame_len_check.sv */
`timescale 1ns/1ps

module frame_len_check import pkt_buf_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  len_t  max_len,
  input  data_t s_tdata,
  input  keep_t s_tkeep,
  input  logic  s_tlast,
  input  logic  s_tuser,
  input  logic  s_tvalid,
  output logic  s_tready,
  output data_t m_tdata,
  output keep_t m_tkeep,
  output logic  m_tlast,
  output logic  m_tuser,
  output logic  m_tvalid,
  input  logic  m_tready
);

  len_t beat_cnt;
  logic beat_xfer;
  logic too_long;

  assign beat_xfer = s_tvalid && m_tready;

  // the current beat is number beat_cnt + 1, so it is over the limit once
  // the beats already seen reach max_len.
  assign too_long = (beat_cnt >= max_len);

  // --------------------------------------------------------------------------
  // beat counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (beat_xfer) begin
      if (s_tlast) begin
        beat_cnt <= '0;
      end else if (beat_cnt != '1) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // pass-through with the bad flag merged on the last beat
  // --------------------------------------------------------------------------

  assign m_tdata  = s_tdata;
  assign m_tkeep  = s_tkeep;
  assign m_tlast  = s_tlast;
  assign m_tvalid = s_tvalid;
  assign s_tready = m_tready;

  always_comb begin
    m_tuser = s_tuser;
    if (s_tlast) begin
      m_tuser = s_tuser || too_long;
    end
  end

endmodule

/* src/frame_stat_regs.sv */
`timescale 1ns/1ps

module frame_stat_regs import pkt_buf_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      good_frame,
  input  logic      bad_frame,
  input  logic      overflow,
  output len_t      max_len
);

  logic       access_req;
  logic       addr_ok;
  logic       wr_en;
  logic [2:0] evt;
  logic [2:0] clr;
  cnt_t       cnt_q [3];

  // --------------------------------------------------------------------------
  // APB handshake
  // --------------------------------------------------------------------------

  // the first access cycle only registers the request, pready follows.
  assign access_req = psel && penable && !pready;

  always_comb begin
    case (paddr)
      REG_MAX_LEN, REG_GOOD_CNT, REG_BAD_CNT, REG_OVF_CNT: addr_ok = 1'b1;
      default: addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= access_req;
      pslverr <= access_req && !addr_ok;
    end
  end

  // writes take effect on the completing cycle.
  assign wr_en = psel && penable && pready && pwrite && addr_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      max_len <= MAX_LEN_RESET;
    end else if (wr_en && (paddr == REG_MAX_LEN)) begin
      max_len <= pwdata[$bits(len_t)-1:0];
    end
  end

  // --------------------------------------------------------------------------
  // frame counters
  // --------------------------------------------------------------------------

  assign evt = {overflow, bad_frame, good_frame};

  always_comb begin
    clr = '0;
    if (wr_en) begin
      case (paddr)
        REG_GOOD_CNT: clr[0] = 1'b1;
        REG_BAD_CNT:  clr[1] = 1'b1;
        REG_OVF_CNT:  clr[2] = 1'b1;
        default:      clr    = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (rst || clr[i]) begin
        cnt_q[i] <= '0;
      end else if (evt[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  always_comb begin
    case (paddr)
      REG_MAX_LEN:  prdata = data_t'(max_len);
      REG_GOOD_CNT: prdata = cnt_q[0];
      REG_BAD_CNT:  prdata = cnt_q[1];
      REG_OVF_CNT:  prdata = cnt_q[2];
      default:      prdata = '0;
    endcase
  end

endmodule

/* src/pkt_buf_pkg.sv */
package pkt_buf_pkg;

  // --------------------------------------------------------------------------
  // stream beat fields
  // --------------------------------------------------------------------------

  typedef logic [31:0] data_t;
  typedef logic [3:0]  keep_t;

  // beat counts and the length limit share one width.
  typedef logic [15:0] len_t;

  // --------------------------------------------------------------------------
  // register port
  // --------------------------------------------------------------------------

  typedef logic [31:0] cnt_t;
  typedef logic [7:0]  apb_addr_t;

  localparam apb_addr_t REG_MAX_LEN  = 8'h00;
  localparam apb_addr_t REG_GOOD_CNT = 8'h04;
  localparam apb_addr_t REG_BAD_CNT  = 8'h08;
  localparam apb_addr_t REG_OVF_CNT  = 8'h0C;

  // frames longer than this many beats are marked bad.
  localparam len_t MAX_LEN_RESET = 16'd64;

endpackage

/* src/pkt_buf_top.sv */
`timescale 1ns/1ps

module pkt_buf_top import pkt_buf_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 6,
  parameter bit DROP_WHEN_FULL  = 1'b1
) (
  input  logic      clk,
  input  logic      rst,
  input  data_t     s_tdata,
  input  keep_t     s_tkeep,
  input  logic      s_tlast,
  input  logic      s_tuser,
  input  logic      s_tvalid,
  output logic      s_tready,
  output data_t     m_tdata,
  output keep_t     m_tkeep,
  output logic      m_tlast,
  output logic      m_tvalid,
  input  logic      m_tready,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output logic      pslverr
);

  data_t chk_tdata;
  keep_t chk_tkeep;
  logic  chk_tlast;
  logic  chk_tuser;
  logic  chk_tvalid;
  logic  chk_tready;
  logic  good_frame;
  logic  bad_frame;
  logic  overflow;
  len_t  max_len;

  frame_len_check i_frame_len_check (
    .clk      (clk),
    .rst      (rst),
    .max_len  (max_len),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tlast  (s_tlast),
    .s_tuser  (s_tuser),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (chk_tdata),
    .m_tkeep  (chk_tkeep),
    .m_tlast  (chk_tlast),
    .m_tuser  (chk_tuser),
    .m_tvalid (chk_tvalid),
    .m_tready (chk_tready)
  );

  axis_frame_fifo #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
    .DROP_WHEN_FULL  (DROP_WHEN_FULL)
  ) i_axis_frame_fifo (
    .clk        (clk),
    .rst        (rst),
    .s_tdata    (chk_tdata),
    .s_tkeep    (chk_tkeep),
    .s_tlast    (chk_tlast),
    .s_tuser    (chk_tuser),
    .s_tvalid   (chk_tvalid),
    .s_tready   (chk_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow)
  );

  frame_stat_regs i_frame_stat_regs (
    .clk        (clk),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow),
    .max_len    (max_len)
  );

endmodule

/* verification/pkt_buf_sva.sv */
`timescale 1ns/1ps

module pkt_buf_sva import pkt_buf_pkg::*; (
  input logic  clk,
  input logic  rst,
  input data_t m_tdata,
  input keep_t m_tkeep,
  input logic  m_tlast,
  input logic  m_tvalid,
  input logic  m_tready,
  input logic  psel,
  input logic  penable,
  input logic  pready,
  input logic  good_frame,
  input logic  bad_frame,
  input logic  overflow
);

  // a stalled output beat must not change.
  a_out_stable : assert property (@(posedge clk) disable iff (rst)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable({m_tlast, m_tkeep, m_tdata})))
    else $error("output beat changed while stalled");

  a_pready_in_access : assert property (@(posedge clk) disable iff (rst)
    pready |-> (psel && penable))
    else $error("pready high outside an APB access cycle");

  a_one_pulse : assert property (@(posedge clk) disable iff (rst)
    $onehot0({good_frame, bad_frame, overflow}))
    else $error("more than one frame status pulse in a cycle");

endmodule

bind pkt_buf_top pkt_buf_sva i_pkt_buf_sva (.*);

/* verification/pkt_buf_tb.sv */
`timescale 1ns/1ps

module pkt_buf_tb import pkt_buf_pkg::*; ();

  localparam int FIFO_AW = 6;
  localparam int DEPTH   = 2**FIFO_AW;
  localparam int TIMEOUT = 4000;

  typedef enum logic [1:0] {FATE_GOOD, FATE_BAD, FATE_OVF} fate_t;
  typedef struct packed {logic last; keep_t keep; data_t data;} beat_t;

  logic      clk, rst;
  data_t     s_tdata, m_tdata, pwdata, prdata;
  keep_t     s_tkeep, m_tkeep;
  logic      s_tlast, s_tuser, s_tvalid, s_tready;
  logic      m_tlast, m_tvalid, m_tready;
  apb_addr_t paddr;
  logic      psel, penable, pwrite, pready, pslverr;

  integer seed = 32'he63;
  beat_t  exp_q[$];
  int     errors, beats_seen, frames_sent;
  cnt_t   exp_good, exp_bad, exp_ovf;
  len_t   limit;
  logic   stall_en, ready_next;
  string  abort_msg;
  event   abort_ev;

  pkt_buf_top #(.FIFO_ADDR_WIDTH(FIFO_AW), .DROP_WHEN_FULL(1'b1)) i_pkt_buf_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reference model and comparators
  // --------------------------------------------------------------------------

  function automatic fate_t expected_fate(input int len, input logic user, input len_t lim,
                                          input int free);
    if (user || len > lim) return FATE_BAD;
    if (len > free) return FATE_OVF;
    return FATE_GOOD;
  endfunction

  task automatic check_beat(input data_t got_data, input keep_t got_keep, input logic got_last,
                            input data_t exp_data, input keep_t exp_keep, input logic exp_last);
    if (got_data !== exp_data || got_keep !== exp_keep || got_last !== exp_last) begin
      errors++;
      $display("MISMATCH @%0t: beat %h/%h/%b, expected %h/%h/%b", $time,
               got_data, got_keep, got_last, exp_data, exp_keep, exp_last);
    end
  endtask

  task automatic check_reg(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH @%0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    abort_msg = why;
    -> abort_ev;
    // the watcher process below ends the run within this delay.
    #1;
  endtask

  initial begin
    @(abort_ev);
    $display("%s", abort_msg);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // APB and stream drivers
  // --------------------------------------------------------------------------

  task automatic apb_xfer(input apb_addr_t addr, input logic write, input data_t wdata,
                          output data_t rdata, output logic err);
    int waited = 0;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2 penable = 1'b1;
    @(posedge clk);
    while (!pready) begin
      if (waited >= TIMEOUT) abort_run("timeout waiting for pready");
      waited++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    #2 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input apb_addr_t addr, input data_t wdata);
    data_t rdata;
    logic  err;
    apb_xfer(addr, 1'b1, wdata, rdata, err);
    check_reg("pslverr", cnt_t'(err), '0);
  endtask

  task automatic reg_read(input apb_addr_t addr, output data_t rdata);
    logic err;
    apb_xfer(addr, 1'b0, '0, rdata, err);
    check_reg("pslverr", cnt_t'(err), '0);
  endtask

  // free space is at least DEPTH minus the beats still expected at the output.
  task automatic wait_room(input int need);
    int waited = 0;
    while (DEPTH - exp_q.size() < need) begin
      if (waited >= TIMEOUT) abort_run("timeout waiting for the FIFO to drain");
      waited++;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_frame(input int len, input logic user);
    beat_t beats[$];
    beat_t b;
    int    waited;
    if (len <= DEPTH) wait_room(len);
    for (int i = 0; i < len; i++) begin
      b.data = $random(seed);
      b.keep = (i == len - 1) ? keep_t'({$random(seed)} % 15 + 1) : 4'hf;
      b.last = (i == len - 1);
      beats.push_back(b);
    end
    case (expected_fate(len, user, limit, DEPTH - exp_q.size()))
      FATE_GOOD: begin
        exp_good++;
        foreach (beats[i]) exp_q.push_back(beats[i]);
      end
      FATE_BAD: exp_bad++;
      default:  exp_ovf++;
    endcase
    frames_sent++;
    foreach (beats[i]) begin
      s_tdata  = beats[i].data;
      s_tkeep  = beats[i].keep;
      s_tlast  = beats[i].last;
      s_tuser  = user && beats[i].last;
      s_tvalid = 1'b1;
      waited   = 0;
      @(posedge clk);
      // with full frames dropped the input is never stalled.
      if (!s_tready) begin
        errors++;
        $display("MISMATCH @%0t: s_tready low on an input beat", $time);
      end
      while (!s_tready) begin
        if (waited >= TIMEOUT) abort_run("timeout waiting for s_tready");
        waited++;
        @(posedge clk);
      end
      #2;
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tuser  = 1'b0;
  endtask

  task automatic run_frames(input int n, input int lo, input int hi, input logic mix_bad);
    int   len;
    logic user;
    for (int i = 0; i < n; i++) begin
      len  = lo + {$random(seed)} % (hi - lo + 1);
      user = mix_bad && ({$random(seed)} % 2 != 0);
      send_frame(len, user);
    end
  endtask

  task automatic report_test(input int num, input string name, input int mark);
    $display("test %0d %s: %s (%0d errors)", num, name, (errors == mark) ? "ok" : "failed",
             errors - mark);
  endtask

  // --------------------------------------------------------------------------
  // sink with random back-pressure and output monitor
  // --------------------------------------------------------------------------

  always @(negedge clk) begin
    ready_next = 1'b1;
    if (stall_en) ready_next = ({$random(seed)} % 4 != 0);
  end

  always @(posedge clk) begin
    #2 m_tready = ready_next;
  end

  always @(posedge clk) begin : monitor
    beat_t b;
    if (!rst && m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output beat %h at %0t while no frame was expected", m_tdata, $time);
      end else begin
        b = exp_q.pop_front();
        beats_seen++;
        check_beat(m_tdata, m_tkeep, m_tlast, b.data, b.keep, b.last);
      end
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    data_t rd;
    logic  err;
    int    mark;
    rst = 1'b1;
    {s_tdata, s_tkeep, s_tlast, s_tuser, s_tvalid, m_tready} = '0;
    {paddr, psel, penable, pwrite, pwdata} = '0;
    {stall_en, ready_next} = 2'b01;
    {errors, beats_seen, frames_sent} = '0;
    {exp_good, exp_bad, exp_ovf} = '0;
    limit = MAX_LEN_RESET;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    mark = errors;
    run_frames(20, 1, 40, 1'b0);
    wait_room(DEPTH);
    reg_read(REG_GOOD_CNT, rd);
    check_reg("GOOD_CNT", rd, exp_good);
    report_test(1, "good frames", mark);

    mark = errors;
    stall_en = 1'b1;
    run_frames(30, 1, 40, 1'b0);
    wait_room(DEPTH);
    reg_read(REG_GOOD_CNT, rd);
    check_reg("GOOD_CNT", rd, exp_good);
    report_test(2, "output stalls", mark);

    mark = errors;
    reg_write(REG_MAX_LEN, 32'd10);
    limit = 10;
    run_frames(30, 1, 20, 1'b0);
    wait_room(DEPTH);
    reg_read(REG_BAD_CNT, rd);
    check_reg("BAD_CNT", rd, exp_bad);
    reg_read(REG_GOOD_CNT, rd);
    check_reg("GOOD_CNT", rd, exp_good);
    report_test(3, "length limit", mark);

    mark = errors;
    run_frames(20, 1, 10, 1'b1);
    wait_room(DEPTH);
    reg_read(REG_BAD_CNT, rd);
    check_reg("BAD_CNT", rd, exp_bad);
    report_test(4, "tuser drop", mark);

    mark = errors;
    reg_write(REG_MAX_LEN, 32'd200);
    limit = 200;
    send_frame(80, 1'b0);
    send_frame(12, 1'b0);
    wait_room(DEPTH);
    reg_read(REG_OVF_CNT, rd);
    check_reg("OVF_CNT", rd, exp_ovf);
    reg_read(REG_GOOD_CNT, rd);
    check_reg("GOOD_CNT", rd, exp_good);
    report_test(5, "overflow", mark);

    mark = errors;
    reg_write(REG_MAX_LEN, 32'hABCD_1234);
    reg_read(REG_MAX_LEN, rd);
    check_reg("MAX_LEN", rd, cnt_t'(len_t'(16'h1234)));
    // any write data clears a counter.
    reg_write(REG_BAD_CNT, 32'h5A5A_00FF);
    reg_read(REG_BAD_CNT, rd);
    check_reg("BAD_CNT", rd, '0);
    apb_xfer(8'h20, 1'b0, '0, rd, err);
    check_reg("pslverr at 0x20", cnt_t'(err), 1);
    report_test(6, "registers", mark);

    $display("frames sent %0d, beats checked %0d, errors %0d", frames_sent, beats_seen, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
